// ==== hdl/sfu_csr_unit.sv ====
// ######################################
// CSR element. A three-state FSM reads the old value, updates the
// per-warp scratch register and holds the result until taken.
// ######################################
`timescale 1ns/1ps

module sfu_csr_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  sfu_pkg::sfu_req_t         req,
    output logic                      rsp_valid,
    input  logic                      rsp_ready,
    output sfu_pkg::sfu_rsp_t         rsp,
    input  logic [sfu_pkg::xlen-1:0]  cycle_count,
    input  logic [sfu_pkg::xlen-1:0]  instret_count
);

    import sfu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_respond
    } csr_state_e;

    csr_state_e                     state;
    sfu_req_t                       req_q;
    logic [xlen-1:0]                scratch_q [num_warps];
    logic [xlen-1:0]                old_val;
    logic [xlen-1:0]                new_val;
    logic [xlen-1:0]                src;
    logic [num_lanes-1:0][xlen-1:0] rdata;
    logic [num_lanes-1:0][xlen-1:0] rdata_q;

    assign req_ready = (state == st_idle);
    assign rsp_valid = (state == st_respond);
    assign src       = lead_rs1(req_q.tmask, req_q.rs1_data);

    always_comb begin
        case (req_q.csr_addr)
            csr_scratch:  old_val = scratch_q[req_q.warp_id];
            csr_mcycle:   old_val = cycle_count;
            csr_minstret: old_val = instret_count;
            csr_warp_id:  old_val = {{(xlen - warp_id_w){1'b0}}, req_q.warp_id};
            csr_core_id:  old_val = sfu_core_id;
            default:      old_val = '0;
        endcase
        case (req_q.op)
            op_csrrs: new_val = old_val | src;
            op_csrrc: new_val = old_val & ~src;
            default:  new_val = src;
        endcase
        // Thread id is the only CSR whose value differs across lanes
        for (int i = 0; i < num_lanes; i++) begin
            rdata[i] = (req_q.csr_addr == csr_thread_id) ? xlen'(i) : old_val;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            for (int w = 0; w < num_warps; w++) begin
                scratch_q[w] <= '0;
            end
        end else begin
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        state <= st_access;
                    end
                end
                st_access: begin
                    // Only scratch is writable, other addresses drop the write
                    if (req_q.csr_addr == csr_scratch) begin
                        scratch_q[req_q.warp_id] <= new_val;
                    end
                    state <= st_respond;
                end
                st_respond: begin
                    if (rsp_ready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (state == st_access) begin
            rdata_q <= rdata;
        end
    end

    assign rsp.warp_id = req_q.warp_id;
    assign rsp.tmask   = req_q.tmask;
    assign rsp.rd      = req_q.rd;
    assign rsp.wb      = 1'b1;
    assign rsp.data    = rdata_q;

endmodule

// ==== hdl/sfu_elastic_buf.sv ====
// ######################################
// Two-entry valid/ready buffer with registered outputs.
// The payload type is set through the data_t type parameter.
// ######################################
`timescale 1ns/1ps

module sfu_elastic_buf #(
    parameter type data_t = logic
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  in_valid,
    output logic  in_ready,
    input  data_t in_data,
    output logic  out_valid,
    input  logic  out_ready,
    output data_t out_data
);

    logic  skid_valid;
    data_t skid_data;
    logic  in_fire;
    logic  out_load;

    // The skid entry only fills when the output entry is stalled
    assign in_ready = !skid_valid;
    assign in_fire  = in_valid && in_ready;
    assign out_load = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            out_data <= skid_valid ? skid_data : in_data;
        end
        if (in_fire && !out_load) begin
            skid_data <= in_data;
        end
    end

endmodule

// ==== hdl/sfu_pe_switch.sv ====
// ######################################
// Steers requests to the warp control or CSR element and merges
// their results with a round-robin arbiter.
// ######################################
`timescale 1ns/1ps

module sfu_pe_switch (
    input  logic              clk,
    input  logic              rst_n,

    input  logic              req_valid,
    output logic              req_ready,
    input  sfu_pkg::sfu_req_t req,

    output logic              wctl_req_valid,
    input  logic              wctl_req_ready,
    output logic              csr_req_valid,
    input  logic              csr_req_ready,
    output sfu_pkg::sfu_req_t sub_req,

    input  logic              wctl_rsp_valid,
    output logic              wctl_rsp_ready,
    input  sfu_pkg::sfu_rsp_t wctl_rsp,
    input  logic              csr_rsp_valid,
    output logic              csr_rsp_ready,
    input  sfu_pkg::sfu_rsp_t csr_rsp,

    output logic              rsp_valid,
    input  logic              rsp_ready,
    output sfu_pkg::sfu_rsp_t rsp
);

    import sfu_pkg::*;

    logic is_csr;
    logic grant_csr;
    logic last_csr;

    // Bit 2 of the opcode marks a CSR access
    assign is_csr = req.op[2];

    assign wctl_req_valid = req_valid && !is_csr;
    assign csr_req_valid  = req_valid && is_csr;
    assign req_ready      = is_csr ? csr_req_ready : wctl_req_ready;
    assign sub_req        = req;

    // With both results pending, the element that lost last time wins
    assign grant_csr = csr_rsp_valid && (!wctl_rsp_valid || !last_csr);

    assign rsp_valid      = wctl_rsp_valid || csr_rsp_valid;
    assign rsp            = grant_csr ? csr_rsp : wctl_rsp;
    assign wctl_rsp_ready = rsp_ready && !grant_csr;
    assign csr_rsp_ready  = rsp_ready && grant_csr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            last_csr <= 1'b0;
        end else if (rsp_valid && rsp_ready) begin
            last_csr <= grant_csr;
        end
    end

endmodule

// ==== hdl/sfu_perf_counters.sv ====
// ######################################
// Cycle and retired-instruction counters read through the CSR element
// ######################################
`timescale 1ns/1ps

module sfu_perf_counters (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     commit_fire,
    output logic [sfu_pkg::xlen-1:0] cycle_count,
    output logic [sfu_pkg::xlen-1:0] instret_count
);

    import sfu_pkg::*;

    // Both counters wrap silently at 2**xlen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + xlen'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instret_count <= '0;
        end else if (commit_fire) begin
            instret_count <= instret_count + xlen'(1);
        end
    end

endmodule

// ==== hdl/sfu_pkg.sv ====
// ######################################
// Shared sizes, opcodes, CSR addresses and payload types for the SFU.
// Modules pull these in with a wildcard import.
// ######################################
package sfu_pkg;

    localparam int num_lanes  = 4;
    localparam int num_warps  = 4;
    localparam int warp_id_w  = 2;
    localparam int xlen       = 32;
    localparam int csr_addr_w = 12;

    localparam logic [xlen-1:0] sfu_core_id = 32'd3;

    // Warp control ops sit below 4 and CSR ops have bit 2 set
    typedef enum logic [2:0] {
        op_tmc    = 3'd0,
        op_wspawn = 3'd1,
        op_bar    = 3'd2,
        op_csrrw  = 3'd4,
        op_csrrs  = 3'd5,
        op_csrrc  = 3'd6
    } sfu_op_e;

    localparam logic [csr_addr_w-1:0] csr_scratch   = 12'h340;
    localparam logic [csr_addr_w-1:0] csr_mcycle    = 12'hB00;
    localparam logic [csr_addr_w-1:0] csr_minstret  = 12'hB02;
    localparam logic [csr_addr_w-1:0] csr_thread_id = 12'hCC0;
    localparam logic [csr_addr_w-1:0] csr_warp_id   = 12'hCC1;
    localparam logic [csr_addr_w-1:0] csr_core_id   = 12'hCC2;

    typedef struct packed {
        logic [warp_id_w-1:0]                warp_id;
        logic [num_lanes-1:0]                tmask;
        sfu_op_e                             op;
        logic [4:0]                          rd;
        logic [csr_addr_w-1:0]               csr_addr;
        logic [num_lanes-1:0][xlen-1:0]      rs1_data;
        logic [num_lanes-1:0][xlen-1:0]      rs2_data;
    } sfu_req_t;

    typedef struct packed {
        logic [warp_id_w-1:0]                warp_id;
        logic [num_lanes-1:0]                tmask;
        logic [4:0]                          rd;
        logic                                wb;
        logic [num_lanes-1:0][xlen-1:0]      data;
    } sfu_rsp_t;

    // Scalar operand comes from the lowest active lane
    function automatic logic [xlen-1:0] lead_rs1(
        input logic [num_lanes-1:0]           tmask,
        input logic [num_lanes-1:0][xlen-1:0] rs1
    );
        logic [xlen-1:0] val;
        val = rs1[0];
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (tmask[i]) begin
                val = rs1[i];
            end
        end
        return val;
    endfunction

endpackage

// ==== hdl/sfu_unit.sv ====
// ######################################
// SFU top level. Buffers requests, routes them to warp control or CSR
// and returns results through a buffered commit port.
// ######################################
`timescale 1ns/1ps

module sfu_unit (
    input  logic                                              clk,
    input  logic                                              rst_n,

    input  logic                                              exec_valid,
    output logic                                              exec_ready,
    input  logic [sfu_pkg::warp_id_w-1:0]                     exec_warp_id,
    input  logic [sfu_pkg::num_lanes-1:0]                     exec_tmask,
    input  sfu_pkg::sfu_op_e                                  exec_op,
    input  logic [4:0]                                        exec_rd,
    input  logic [sfu_pkg::csr_addr_w-1:0]                    exec_csr_addr,
    input  logic [sfu_pkg::num_lanes-1:0][sfu_pkg::xlen-1:0]  exec_rs1_data,
    input  logic [sfu_pkg::num_lanes-1:0][sfu_pkg::xlen-1:0]  exec_rs2_data,

    output logic                                              commit_valid,
    input  logic                                              commit_ready,
    output logic [sfu_pkg::warp_id_w-1:0]                     commit_warp_id,
    output logic [sfu_pkg::num_lanes-1:0]                     commit_tmask,
    output logic [4:0]                                        commit_rd,
    output logic                                              commit_wb,
    output logic [sfu_pkg::num_lanes-1:0][sfu_pkg::xlen-1:0]  commit_data,

    output logic                                              warp_ctl_valid,
    output sfu_pkg::sfu_op_e                                  warp_ctl_op,
    output logic [sfu_pkg::warp_id_w-1:0]                     warp_ctl_warp_id,
    output logic [sfu_pkg::num_lanes-1:0]                     warp_ctl_tmask,
    output logic [sfu_pkg::xlen-1:0]                          warp_ctl_arg
);

    import sfu_pkg::*;

    sfu_req_t        exec_req, buf_req, sub_req;
    sfu_rsp_t        wctl_rsp, csr_rsp, sw_rsp, commit_rsp;
    logic            buf_valid, buf_ready;
    logic            wctl_req_valid, wctl_req_ready, csr_req_valid, csr_req_ready;
    logic            wctl_rsp_valid, wctl_rsp_ready, csr_rsp_valid, csr_rsp_ready;
    logic            sw_rsp_valid, sw_rsp_ready;
    logic [xlen-1:0] cycle_count, instret_count;

    assign exec_req = '{warp_id: exec_warp_id, tmask: exec_tmask, op: exec_op,
                        rd: exec_rd, csr_addr: exec_csr_addr,
                        rs1_data: exec_rs1_data, rs2_data: exec_rs2_data};

    sfu_elastic_buf #(.data_t(sfu_req_t)) i_req_buf (
        .clk(clk), .rst_n(rst_n),
        .in_valid(exec_valid), .in_ready(exec_ready), .in_data(exec_req),
        .out_valid(buf_valid), .out_ready(buf_ready), .out_data(buf_req)
    );

    sfu_pe_switch i_pe_switch (
        .clk(clk), .rst_n(rst_n),
        .req_valid(buf_valid), .req_ready(buf_ready), .req(buf_req),
        .wctl_req_valid(wctl_req_valid), .wctl_req_ready(wctl_req_ready),
        .csr_req_valid(csr_req_valid), .csr_req_ready(csr_req_ready),
        .sub_req(sub_req),
        .wctl_rsp_valid(wctl_rsp_valid), .wctl_rsp_ready(wctl_rsp_ready),
        .wctl_rsp(wctl_rsp),
        .csr_rsp_valid(csr_rsp_valid), .csr_rsp_ready(csr_rsp_ready), .csr_rsp(csr_rsp),
        .rsp_valid(sw_rsp_valid), .rsp_ready(sw_rsp_ready), .rsp(sw_rsp)
    );

    sfu_wctl_unit i_wctl_unit (
        .clk(clk), .rst_n(rst_n),
        .req_valid(wctl_req_valid), .req_ready(wctl_req_ready), .req(sub_req),
        .rsp_valid(wctl_rsp_valid), .rsp_ready(wctl_rsp_ready), .rsp(wctl_rsp),
        .warp_ctl_valid(warp_ctl_valid), .warp_ctl_op(warp_ctl_op),
        .warp_ctl_warp_id(warp_ctl_warp_id), .warp_ctl_tmask(warp_ctl_tmask),
        .warp_ctl_arg(warp_ctl_arg)
    );

    sfu_csr_unit i_csr_unit (
        .clk(clk), .rst_n(rst_n),
        .req_valid(csr_req_valid), .req_ready(csr_req_ready), .req(sub_req),
        .rsp_valid(csr_rsp_valid), .rsp_ready(csr_rsp_ready), .rsp(csr_rsp),
        .cycle_count(cycle_count), .instret_count(instret_count)
    );

    sfu_elastic_buf #(.data_t(sfu_rsp_t)) i_rsp_buf (
        .clk(clk), .rst_n(rst_n),
        .in_valid(sw_rsp_valid), .in_ready(sw_rsp_ready), .in_data(sw_rsp),
        .out_valid(commit_valid), .out_ready(commit_ready), .out_data(commit_rsp)
    );

    sfu_perf_counters i_perf_counters (
        .clk(clk), .rst_n(rst_n),
        .commit_fire(commit_valid && commit_ready),
        .cycle_count(cycle_count), .instret_count(instret_count)
    );

    assign commit_warp_id = commit_rsp.warp_id;
    assign commit_tmask   = commit_rsp.tmask;
    assign commit_rd      = commit_rsp.rd;
    assign commit_wb      = commit_rsp.wb;
    assign commit_data    = commit_rsp.data;

endmodule

// ==== hdl/sfu_wctl_unit.sv ====
// ######################################
// Warp control element. Issues a one-cycle scheduler pulse for
// TMC, WSPAWN and BAR and returns a result with no writeback.
// ######################################
`timescale 1ns/1ps

module sfu_wctl_unit (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    req_valid,
    output logic                                    req_ready,
    input  sfu_pkg::sfu_req_t                       req,
    output logic                                    rsp_valid,
    input  logic                                    rsp_ready,
    output sfu_pkg::sfu_rsp_t                       rsp,
    output logic                                    warp_ctl_valid,
    output sfu_pkg::sfu_op_e                        warp_ctl_op,
    output logic [sfu_pkg::warp_id_w-1:0]           warp_ctl_warp_id,
    output logic [sfu_pkg::num_lanes-1:0]           warp_ctl_tmask,
    output logic [sfu_pkg::xlen-1:0]                warp_ctl_arg
);

    import sfu_pkg::*;

    logic            req_fire;
    logic [xlen-1:0] src;

    // One result register, so only accept when it is free
    assign req_ready = !rsp_valid;
    assign req_fire  = req_valid && req_ready;
    assign src       = lead_rs1(req.tmask, req.rs1_data);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid      <= 1'b0;
            warp_ctl_valid <= 1'b0;
        end else begin
            warp_ctl_valid <= req_fire;
            if (req_fire) begin
                rsp_valid <= 1'b1;
            end else if (rsp_ready) begin
                rsp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            warp_ctl_op      <= req.op;
            warp_ctl_warp_id <= req.warp_id;
            warp_ctl_tmask   <= (req.op == op_tmc) ? src[num_lanes-1:0] : '0;
            warp_ctl_arg     <= (req.op == op_tmc) ? '0 : src;
            rsp.warp_id      <= req.warp_id;
            rsp.tmask        <= req.tmask;
            rsp.rd           <= req.rd;
            rsp.wb           <= 1'b0;
            rsp.data         <= '0;
        end
    end

endmodule

// ==== sfu_unit.f ====
hdl/sfu_pkg.sv
hdl/sfu_elastic_buf.sv
hdl/sfu_pe_switch.sv
hdl/sfu_wctl_unit.sv
hdl/sfu_csr_unit.sv
hdl/sfu_perf_counters.sv
hdl/sfu_unit.sv
verification/tb_sfu_unit.sv

// ==== verification/tb_sfu_unit.sv ====
// ########################################
// Self-checking testbench for the SFU. Drives the exec port and checks
// commits and scheduler pulses against a reference model.
// ########################################
`timescale 1ns/1ps

module tb_sfu_unit;

    import sfu_pkg::*;

    typedef enum logic [1:0] {kind_exact, kind_cycle, kind_instret} exp_kind_e;

    typedef struct packed {
        logic [warp_id_w-1:0]           warp_id;
        logic [num_lanes-1:0]           tmask;
        logic [4:0]                     rd;
        exp_kind_e                      kind;
        logic [num_lanes-1:0][xlen-1:0] data;
    } exp_rsp_t;

    typedef struct packed {
        sfu_op_e              op;
        logic [warp_id_w-1:0] warp_id;
        logic [xlen-1:0]      value;
    } exp_ctl_t;

    logic                           clk;
    logic                           rst_n;
    logic                           exec_valid;
    logic                           exec_ready;
    logic [warp_id_w-1:0]           exec_warp_id;
    logic [num_lanes-1:0]           exec_tmask;
    sfu_op_e                        exec_op;
    logic [4:0]                     exec_rd;
    logic [csr_addr_w-1:0]          exec_csr_addr;
    logic [num_lanes-1:0][xlen-1:0] exec_rs1_data;
    logic [num_lanes-1:0][xlen-1:0] exec_rs2_data;
    logic                           commit_valid;
    logic                           commit_ready;
    logic [warp_id_w-1:0]           commit_warp_id;
    logic [num_lanes-1:0]           commit_tmask;
    logic [4:0]                     commit_rd;
    logic                           commit_wb;
    logic [num_lanes-1:0][xlen-1:0] commit_data;
    logic                           warp_ctl_valid;
    sfu_op_e                        warp_ctl_op;
    logic [warp_id_w-1:0]           warp_ctl_warp_id;
    logic [num_lanes-1:0]           warp_ctl_tmask;
    logic [xlen-1:0]                warp_ctl_arg;

    exp_rsp_t        wctl_q[$];
    exp_rsp_t        csr_q[$];
    exp_ctl_t        ctl_q[$];
    logic [xlen-1:0] scratch_model [num_warps];
    logic [xlen-1:0] last_cycle;
    logic [xlen-1:0] last_instret;
    int              last_instret_idx;
    logic            have_cycle = 1'b0;
    logic            have_instret = 1'b0;
    logic            rand_ready;
    logic            timed_out = 1'b0;
    integer          seed = 54287;
    int              errors = 0;
    int              checks = 0;
    int              tests = 0;
    int              commit_total = 0;
    int              test_commits = 0;
    string           cur_test = "none";

    sfu_unit i_sfu_unit (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        commit_ready = 1'b1;
        forever begin
            @(negedge clk);
            commit_ready = rand_ready ? (($random(seed) & 1) == 1) : 1'b1;
        end
    end

    initial begin
        wait (timed_out);
        $display("TEST FAILED");
        $finish;
    end

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> exec_ready && !commit_valid && !warp_ctl_valid)
        else begin
            errors++;
            $display("Outputs were not idle on the first cycle after reset");
        end

    a_ctl_single: assert property (@(posedge clk) disable iff (!rst_n)
        warp_ctl_valid |=> !warp_ctl_valid)
        else begin
            errors++;
            $display("Scheduler pulse in test %s lasted more than one cycle", cur_test);
        end

    a_commit_hold: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_ready |=> commit_valid
        && $stable({commit_warp_id, commit_tmask, commit_rd, commit_wb, commit_data}))
        else begin
            errors++;
            $display("Commit in test %s changed or dropped while stalled", cur_test);
        end

    a_commit_known: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> !$isunknown({commit_wb, commit_warp_id, commit_tmask, commit_rd}))
        else begin
            errors++;
            $display("Commit in test %s carried unknown bits", cur_test);
        end

    task automatic check_value(input string what, input logic [xlen-1:0] exp,
                               input logic [xlen-1:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("[ERROR] %s: %s expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("Test %s: %s did not hold", cur_test, what);
        end
    endtask

    task automatic stall_on_timeout(input string what);
        $display("Test %s timed out while waiting for %s", cur_test, what);
        timed_out = 1'b1;
        forever @(negedge clk);
    endtask

    function automatic int lead_lane(input logic [num_lanes-1:0] tmask);
        int   lane;
        logic found;
        lane  = 0;
        found = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            if (tmask[i] && !found) begin
                lane  = i;
                found = 1'b1;
            end
        end
        return lane;
    endfunction

    // Commits are matched to the element queue that the writeback flag selects
    always @(posedge clk) begin
        exp_rsp_t e;
        logic     pending;
        if (rst_n && commit_valid && commit_ready) begin
            pending = commit_wb ? (csr_q.size() != 0) : (wctl_q.size() != 0);
            assert (pending) else begin
                errors++;
                $display("Test %s: a commit arrived with no result pending", cur_test);
            end
            if (pending) begin
                e = commit_wb ? csr_q.pop_front() : wctl_q.pop_front();
                check_value("warp id", e.warp_id, commit_warp_id);
                check_value("tmask", e.tmask, commit_tmask);
                check_value("rd", e.rd, commit_rd);
                for (int i = 0; i < num_lanes; i++) begin
                    if (e.kind == kind_exact) begin
                        check_value($sformatf("lane %0d data", i), e.data[i], commit_data[i]);
                    end else if (i != 0) begin
                        check_value("counter lane", commit_data[0], commit_data[i]);
                    end
                end
                if (e.kind == kind_cycle) begin
                    if (have_cycle) begin
                        check_true("mcycle increase", commit_data[0] > last_cycle);
                    end
                    last_cycle = commit_data[0];
                    have_cycle = 1'b1;
                end else if (e.kind == kind_instret) begin
                    if (have_instret) begin
                        check_value("minstret step", commit_total - last_instret_idx,
                                    commit_data[0] - last_instret);
                    end
                    last_instret     = commit_data[0];
                    last_instret_idx = commit_total;
                    have_instret     = 1'b1;
                end
            end
            commit_total++;
            test_commits++;
        end
    end

    always @(posedge clk) begin
        exp_ctl_t c;
        if (rst_n && warp_ctl_valid) begin
            assert (ctl_q.size() != 0) else begin
                errors++;
                $display("Test %s: a scheduler pulse came with no request pending", cur_test);
            end
            if (ctl_q.size() != 0) begin
                c = ctl_q.pop_front();
                check_value("ctl op", c.op, warp_ctl_op);
                check_value("ctl warp id", c.warp_id, warp_ctl_warp_id);
                if (c.op == op_tmc) begin
                    check_value("ctl tmask", c.value[num_lanes-1:0], warp_ctl_tmask);
                end else begin
                    check_value("ctl arg", c.value, warp_ctl_arg);
                end
            end
        end
    end

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_req(input logic [warp_id_w-1:0] warp, input logic [num_lanes-1:0] tmask,
                            input sfu_op_e op, input logic [4:0] rd,
                            input logic [csr_addr_w-1:0] addr,
                            input logic [num_lanes-1:0][xlen-1:0] rs1);
        exp_rsp_t        e;
        exp_ctl_t        c;
        logic [xlen-1:0] src;
        logic [xlen-1:0] old;
        int              waited;
        src = rs1[lead_lane(tmask)];
        e   = '0;
        c   = '0;
        e.warp_id = warp;
        e.tmask   = tmask;
        e.rd      = rd;
        e.kind    = kind_exact;
        if (op inside {op_tmc, op_wspawn, op_bar}) begin
            c.op      = op;
            c.warp_id = warp;
            c.value   = src;
            ctl_q.push_back(c);
            wctl_q.push_back(e);
        end else begin
            old = '0;
            case (addr)
                csr_scratch:  old = scratch_model[warp];
                csr_warp_id:  old = xlen'(warp);
                csr_core_id:  old = sfu_core_id;
                csr_mcycle:   e.kind = kind_cycle;
                csr_minstret: e.kind = kind_instret;
                default:      old = '0;
            endcase
            for (int i = 0; i < num_lanes; i++) begin
                e.data[i] = (addr == csr_thread_id) ? xlen'(i) : old;
            end
            if (addr == csr_scratch) begin
                case (op)
                    op_csrrw: scratch_model[warp] = src;
                    op_csrrs: scratch_model[warp] = old | src;
                    default:  scratch_model[warp] = old & ~src;
                endcase
            end
            csr_q.push_back(e);
        end
        exec_warp_id  = warp;
        exec_tmask    = tmask;
        exec_op       = op;
        exec_rd       = rd;
        exec_csr_addr = addr;
        exec_rs1_data = rs1;
        exec_rs2_data = ~rs1;
        exec_valid    = 1'b1;
        waited        = 0;
        while (!exec_ready) begin
            if (waited == 200) begin
                stall_on_timeout("exec_ready");
            end
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        exec_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (wctl_q.size() != 0 || csr_q.size() != 0 || ctl_q.size() != 0) begin
            if (waited == 2000) begin
                stall_on_timeout("outstanding results");
            end
            @(negedge clk);
            waited++;
        end
        // Idle cycles give a stray commit or pulse the chance to show up
        repeat (4) @(negedge clk);
    endtask

    task automatic start_test(input string name, input logic random_ready);
        cur_test     = name;
        test_commits = 0;
        rand_ready   = random_ready;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %-10s finished: %0d commits, %0d errors so far",
                 cur_test, test_commits, errors);
    endtask

    initial begin
        logic [num_lanes-1:0][xlen-1:0] rs1;
        sfu_op_e                        op;
        logic [csr_addr_w-1:0]          addr;
        rst_n         = 1'b0;
        rand_ready    = 1'b0;
        exec_valid    = 1'b0;
        exec_warp_id  = '0;
        exec_tmask    = '0;
        exec_op       = op_tmc;
        exec_rd       = '0;
        exec_csr_addr = '0;
        exec_rs1_data = '0;
        exec_rs2_data = '0;
        for (int w = 0; w < num_warps; w++) begin
            scratch_model[w] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        start_test("reset", 1'b0);
        @(negedge clk);
        check_true("exec_ready high", exec_ready);
        check_true("commit_valid low", !commit_valid);
        check_true("warp_ctl_valid low", !warp_ctl_valid);
        end_test();

        start_test("warp_ctl", 1'b0);
        send_req(2'd1, 4'b0110, op_tmc, 5'd3, '0, {32'h0, 32'h0, 32'hB, 32'hF});
        send_req(2'd2, 4'b1000, op_wspawn, 5'd4, '0, {32'd3, 32'd9, 32'd9, 32'd9});
        send_req(2'd3, 4'b1111, op_bar, 5'd0, '0, {32'd1, 32'd2, 32'd3, 32'd5});
        wait_drain();
        end_test();

        start_test("scratch", 1'b1);
        send_req(2'd0, 4'b0001, op_csrrw, 5'd1, csr_scratch, {4{32'h1234_5678}});
        send_req(2'd1, 4'b0010, op_csrrw, 5'd2, csr_scratch, {32'h0, 32'h0, 32'hA5A5_0000, 32'h0});
        send_req(2'd0, 4'b0100, op_csrrs, 5'd3, csr_scratch, {32'h0, 32'hF0, 32'h0, 32'h0});
        send_req(2'd1, 4'b1111, op_csrrc, 5'd4, csr_scratch, {32'h0, 32'h0, 32'h0, 32'hA500_0000});
        send_req(2'd0, 4'b0001, op_csrrs, 5'd5, csr_scratch, '0);
        send_req(2'd1, 4'b0001, op_csrrs, 5'd6, csr_scratch, '0);
        send_req(2'd2, 4'b0001, op_csrrs, 5'd7, csr_scratch, '0);
        wait_drain();
        end_test();

        start_test("id_csrs", 1'b0);
        send_req(2'd2, 4'b1111, op_csrrs, 5'd1, csr_thread_id, '0);
        send_req(2'd3, 4'b0011, op_csrrs, 5'd2, csr_warp_id, '0);
        send_req(2'd1, 4'b1111, op_csrrs, 5'd3, csr_core_id, '0);
        send_req(2'd2, 4'b1111, op_csrrw, 5'd4, csr_thread_id, {4{32'hFFFF_FFFF}});
        send_req(2'd3, 4'b0011, op_csrrw, 5'd5, csr_warp_id, {4{32'hFFFF_FFFF}});
        send_req(2'd1, 4'b1111, op_csrrw, 5'd6, csr_core_id, {4{32'hFFFF_FFFF}});
        send_req(2'd2, 4'b1111, op_csrrs, 5'd7, csr_thread_id, '0);
        send_req(2'd3, 4'b0011, op_csrrs, 5'd8, csr_warp_id, '0);
        send_req(2'd1, 4'b1111, op_csrrs, 5'd9, csr_core_id, '0);
        wait_drain();
        end_test();

        // Each request drains before the next, so minstret sees every earlier commit
        start_test("counters", 1'b1);
        send_req(2'd0, 4'b0001, op_csrrs, 5'd1, csr_mcycle, '0);
        wait_drain();
        send_req(2'd1, 4'b0001, op_csrrs, 5'd2, csr_mcycle, '0);
        wait_drain();
        send_req(2'd2, 4'b0001, op_csrrs, 5'd3, csr_minstret, '0);
        wait_drain();
        for (int n = 0; n < 3; n++) begin
            send_req(2'(n), 4'b0001, op_tmc, 5'd4, '0, {4{32'hF}});
            wait_drain();
        end
        send_req(2'd3, 4'b0001, op_csrrs, 5'd5, csr_minstret, '0);
        wait_drain();
        end_test();

        start_test("random", 1'b1);
        for (int n = 0; n < 40; n++) begin
            case ({$random(seed)} % 6)
                0:       op = op_tmc;
                1:       op = op_wspawn;
                2:       op = op_bar;
                3:       op = op_csrrw;
                4:       op = op_csrrs;
                default: op = op_csrrc;
            endcase
            case ({$random(seed)} % 5)
                0:       addr = csr_thread_id;
                1:       addr = csr_warp_id;
                2:       addr = csr_core_id;
                default: addr = csr_scratch;
            endcase
            for (int i = 0; i < num_lanes; i++) begin
                rs1[i] = $random(seed);
            end
            send_req(2'($random(seed)), 4'($random(seed)), op, 5'($random(seed)), addr, rs1);
        end
        wait_drain();
        check_value("commit count", 40, test_commits);
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
